/* hw/sd_config.svh */
`ifndef SD_CONFIG_SVH
`define SD_CONFIG_SVH

// Frame lengths on the CMD line
`define SD_CMD_BITS     48
`define SD_RESP_BITS    48

// Start, transmit, index and argument bits
`define SD_CRC_SPAN     40

// Cycles from respValid to the first response bit, at least 2
`define SD_NCR_CYCLES   2

// Address handed out by CMD3
`define SD_ASSIGNED_RCA 16'hAAAA

// ACMD41 reply: power-up done, CCS set, 2.7V to 3.6V window
`define SD_OCR_READY    32'hC0FF8000

`endif

/* hw/sdCmdPkg.sv */
package sdCmdPkg;

    // Application flag in bit 6, command index below
    typedef enum logic [6:0] {
        opGoIdle       = 7'h00,
        opSendRca      = 7'h03,
        opSelect       = 7'h07,
        opSendIfCond   = 7'h08,
        opAppCmd       = 7'h37,
        opSdSendOpCond = 7'h69,
        opUnknown      = 7'h7F
    } cmdOpcode;

    // Fields of a captured command frame
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic        crcOk;
        logic        framingOk;
    } cmdFrame;

    // Only ACMD41 depends on the CMD55 prefix
    function automatic cmdOpcode decodeOpcode(input logic app, input logic [5:0] index);
        cmdOpcode op;
        case ({1'b0, index})
            opGoIdle, opSendRca, opSelect, opSendIfCond, opAppCmd: op = cmdOpcode'({1'b0, index});
            default: op = opUnknown;
        endcase
        if (app && {1'b1, index} == opSdSendOpCond) begin
            op = opSdSendOpCond;
        end
        return op;
    endfunction

endpackage

/* hw/sdRespPkg.sv */
package sdRespPkg;

    // Card states as reported in status bits 12:9
    typedef enum logic [3:0] {
        stIdle  = 4'd0,
        stReady = 4'd1,
        stStby  = 4'd3,
        stTran  = 4'd4
    } cardState;

    // Response formats, all 48 bits long
    typedef enum logic [1:0] {
        rkR1,
        rkR3,
        rkR6,
        rkR7
    } respKind;

    // Response contents before framing and CRC
    typedef struct packed {
        respKind     kind;
        logic [5:0]  index;
        logic [31:0] arg;
    } respFrame;

endpackage

/* hw/sdCrc7.sv */
`timescale 1ns/1ps

module sdCrc7 (
    input  logic       clk,
    input  logic       rst_,
    input  logic       clear,
    input  logic       advance,
    input  logic       bitIn,
    output logic [6:0] crc
);

    logic [6:0] base;
    logic       feedback;
    logic [6:0] crcNext;

    // Clear together with advance starts a new frame on this bit
    assign base     = clear ? 7'd0 : crc;
    assign feedback = bitIn ^ base[6];
    // x^7 + x^3 + 1
    assign crcNext  = {base[5:3], base[2] ^ feedback, base[1:0], feedback};

    always_ff @(posedge clk) begin
        if (!rst_) begin
            crc <= 7'd0;
        end else if (advance) begin
            crc <= crcNext;
        end else if (clear) begin
            crc <= 7'd0;
        end
    end

endmodule

/* hw/sdCmdReceiver.sv */
`timescale 1ns/1ps
`include "sd_config.svh"

module sdCmdReceiver import sdCmdPkg::*; (
    input  logic    clk,
    input  logic    rst_,
    input  logic    cmdIn,
    input  logic    respBusy,
    output logic    cmdValid,
    output cmdFrame cmd
);

    typedef enum logic {
        rxIdle,
        rxRecv
    } rxState;

    rxState                  state;
    logic [5:0]              bitCnt;
    logic [`SD_CMD_BITS-2:0] shiftReg;
    logic [`SD_CMD_BITS-1:0] frame;
    logic                    startBit;
    logic                    lastBit;
    logic                    crcAdvance;
    logic [6:0]              crc;

    // ================================================
    // Bit capture
    // ================================================
    // Line is half duplex, so no start bits while a reply is pending
    assign startBit = state == rxIdle && !respBusy && !cmdIn;
    assign lastBit  = state == rxRecv && bitCnt == 6'(`SD_CMD_BITS - 1);

    // 48th bit comes straight from the pin
    assign frame = {shiftReg, cmdIn};

    assign crcAdvance = startBit || (state == rxRecv && bitCnt < 6'(`SD_CRC_SPAN));

    sdCrc7 crcCheck (
        .clk     (clk),
        .rst_    (rst_),
        .clear   (startBit),
        .advance (crcAdvance),
        .bitIn   (cmdIn),
        .crc     (crc)
    );

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state    <= rxIdle;
            bitCnt   <= 6'd0;
            cmdValid <= 1'b0;
        end else begin
            cmdValid <= lastBit;
            case (state)
                rxIdle: begin
                    if (startBit) begin
                        state  <= rxRecv;
                        bitCnt <= 6'd1;
                    end
                end
                rxRecv: begin
                    if (lastBit) begin
                        state <= rxIdle;
                    end else begin
                        bitCnt <= bitCnt + 6'd1;
                    end
                end
                default: state <= rxIdle;
            endcase
        end
    end

    // ================================================
    // Frame checks and publish
    // ================================================
    always_ff @(posedge clk) begin
        shiftReg <= frame[`SD_CMD_BITS-2:0];
        if (lastBit) begin
            cmd.index     <= frame[45:40];
            cmd.arg       <= frame[39:8];
            cmd.crcOk     <= frame[7:1] == crc;
            // Start 0, transmit 1, end 1
            cmd.framingOk <= !frame[47] && frame[46] && frame[0];
        end
    end

endmodule

/* hw/sdCmdDecoder.sv */
`timescale 1ns/1ps
`include "sd_config.svh"

module sdCmdDecoder import sdCmdPkg::*, sdRespPkg::*; (
    input  logic     clk,
    input  logic     rst_,
    input  logic     cmdValid,
    input  cmdFrame  cmd,
    output logic     respValid,
    output respFrame resp
);

    cardState    state;
    cardState    stateNext;
    logic [15:0] rca;
    logic [15:0] rcaNext;
    logic        appPending;
    logic        appNext;
    logic        comCrcError;
    logic        crcErrNext;
    logic        illegalCommand;
    logic        illegalNext;
    logic        respond;
    respFrame    respNext;
    cmdOpcode    op;

    // Card status word carried by R1
    function automatic logic [31:0] r1Status(input cardState st, input logic crcErr,
                                             input logic illegal, input logic appCmd);
        return {8'd0, crcErr, illegal, 9'd0, st, 3'd0, appCmd, 5'd0};
    endfunction

    assign op = decodeOpcode(appPending, cmd.index);

    always_comb begin
        stateNext   = state;
        rcaNext     = rca;
        appNext     = appPending;
        crcErrNext  = comCrcError;
        illegalNext = illegalCommand;
        respond     = 1'b0;
        respNext    = '{kind: rkR1, index: cmd.index, arg: 32'd0};
        if (cmdValid) begin
            // Any command consumes the prefix
            appNext = 1'b0;
            if (!cmd.crcOk || !cmd.framingOk) begin
                crcErrNext = 1'b1;
            end else begin
                case (op)
                    opGoIdle: begin
                        stateNext = stIdle;
                        rcaNext   = 16'd0;
                    end
                    opSendIfCond: begin
                        respond      = 1'b1;
                        respNext     = '{kind: rkR7, index: 6'd8, arg: {20'd0, cmd.arg[11:0]}};
                    end
                    opAppCmd: begin
                        respond      = 1'b1;
                        appNext      = 1'b1;
                        respNext.arg = r1Status(state, comCrcError, illegalCommand, 1'b1);
                        crcErrNext   = 1'b0;
                        illegalNext  = 1'b0;
                    end
                    opSdSendOpCond: begin
                        respond   = 1'b1;
                        respNext  = '{kind: rkR3, index: 6'h3F, arg: `SD_OCR_READY};
                        stateNext = stReady;
                    end
                    opSendRca: begin
                        respond       = 1'b1;
                        respNext.kind = rkR6;
                        // Short status: bits 15, 14 and 12:9 of the full word
                        respNext.arg  = {`SD_ASSIGNED_RCA, comCrcError, illegalCommand, 1'b0,
                                         state, 9'd0};
                        rcaNext       = `SD_ASSIGNED_RCA;
                        stateNext     = stStby;
                        crcErrNext    = 1'b0;
                        illegalNext   = 1'b0;
                    end
                    opSelect: begin
                        // Other addresses deselect, so silence
                        if (cmd.arg[31:16] == rca && rca != 16'd0) begin
                            respond      = 1'b1;
                            respNext.arg = r1Status(state, comCrcError, illegalCommand, 1'b0);
                            stateNext    = stTran;
                            crcErrNext   = 1'b0;
                            illegalNext  = 1'b0;
                        end
                    end
                    default: illegalNext = 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state          <= stIdle;
            rca            <= 16'd0;
            appPending     <= 1'b0;
            comCrcError    <= 1'b0;
            illegalCommand <= 1'b0;
            respValid      <= 1'b0;
        end else begin
            state          <= stateNext;
            rca            <= rcaNext;
            appPending     <= appNext;
            comCrcError    <= crcErrNext;
            illegalCommand <= illegalNext;
            respValid      <= respond;
        end
    end

    always_ff @(posedge clk) begin
        if (respond) begin
            resp <= respNext;
        end
    end

endmodule

/* hw/sdRespTransmitter.sv */
`timescale 1ns/1ps
`include "sd_config.svh"

module sdRespTransmitter import sdRespPkg::*; (
    input  logic     clk,
    input  logic     rst_,
    input  logic     respValid,
    input  respFrame resp,
    output logic     respBusy,
    output logic     cmdOut,
    output logic     cmdOutEn
);

    typedef enum logic [1:0] {
        txIdle,
        txGap,
        txSend
    } txState;

    txState                   state;
    logic [5:0]               bitCnt;
    logic [3:0]               gapCnt;
    logic [`SD_RESP_BITS-1:0] txShift;
    logic                     useCrc;
    logic                     load;
    logic                     crcPhase;
    logic                     crcAdvance;
    logic [2:0]               crcPos;
    logic [6:0]               crc;

    assign load       = respValid && state == txIdle;
    assign respBusy   = respValid || state != txIdle;
    assign cmdOutEn   = state == txSend;
    assign crcAdvance = cmdOutEn && bitCnt < 6'(`SD_CRC_SPAN);

    // CRC bits 40..46 are muxed in from the generator, MSB first
    assign crcPhase = useCrc && bitCnt >= 6'(`SD_CRC_SPAN) && bitCnt < 6'(`SD_RESP_BITS - 1);
    assign crcPos   = 3'(6'(`SD_RESP_BITS - 2) - bitCnt);
    assign cmdOut   = !cmdOutEn ? 1'b1 : crcPhase ? crc[crcPos] : txShift[`SD_RESP_BITS-1];

    sdCrc7 crcGen (
        .clk     (clk),
        .rst_    (rst_),
        .clear   (load),
        .advance (crcAdvance),
        .bitIn   (txShift[`SD_RESP_BITS-1]),
        .crc     (crc)
    );

    // ================================================
    // Gap timer and bit counter
    // ================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state  <= txIdle;
            bitCnt <= 6'd0;
            gapCnt <= 4'd0;
        end else begin
            case (state)
                txIdle: begin
                    if (load) begin
                        state  <= txGap;
                        gapCnt <= 4'(`SD_NCR_CYCLES - 1);
                    end
                end
                txGap: begin
                    if (gapCnt == 4'd1) begin
                        state  <= txSend;
                        bitCnt <= 6'd0;
                    end else begin
                        gapCnt <= gapCnt - 4'd1;
                    end
                end
                txSend: begin
                    if (bitCnt == 6'(`SD_RESP_BITS - 1)) begin
                        state <= txIdle;
                    end else begin
                        bitCnt <= bitCnt + 6'd1;
                    end
                end
                default: state <= txIdle;
            endcase
        end
    end

    // ================================================
    // Serializer
    // ================================================
    always_ff @(posedge clk) begin
        if (load) begin
            // R3 carries all ones in the index and CRC fields
            txShift <= {2'b00, (resp.kind == rkR3) ? 6'h3F : resp.index, resp.arg, 7'h7F, 1'b1};
            useCrc  <= resp.kind != rkR3;
        end else if (cmdOutEn) begin
            txShift <= {txShift[`SD_RESP_BITS-2:0], 1'b1};
        end
    end

endmodule

/* hw/sdCardCmdPath.sv */
`timescale 1ns/1ps

module sdCardCmdPath import sdCmdPkg::*, sdRespPkg::*; (
    input  logic clk,
    input  logic rst_,
    input  logic cmdIn,
    output logic cmdOut,
    output logic cmdOutEn
);

    logic     cmdValid;
    cmdFrame  cmd;
    logic     respValid;
    respFrame resp;
    logic     respBusy;

    // Capture and check
    sdCmdReceiver receiver (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .respBusy (respBusy),
        .cmdValid (cmdValid),
        .cmd      (cmd)
    );

    // Card state and reply selection
    sdCmdDecoder decoder (
        .clk       (clk),
        .rst_      (rst_),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .respValid (respValid),
        .resp      (resp)
    );

    // Drives the line, busy goes back to the receiver
    sdRespTransmitter transmitter (
        .clk       (clk),
        .rst_      (rst_),
        .respValid (respValid),
        .resp      (resp),
        .respBusy  (respBusy),
        .cmdOut    (cmdOut),
        .cmdOutEn  (cmdOutEn)
    );

endmodule

/* verification/sdCardCmdPath_checker.sv */
`timescale 1ns/1ps
`include "sd_config.svh"

module sdCardCmdPath_checker (
    input logic clk,
    input logic rst_,
    input logic cmdOut,
    input logic cmdOutEn
);

    logic [6:0] runLen;

    // Length of the current drive burst
    always_ff @(posedge clk) begin
        if (!rst_) begin
            runLen <= 7'd0;
        end else if (cmdOutEn) begin
            runLen <= runLen + 7'd1;
        end else begin
            runLen <= 7'd0;
        end
    end

    // ================================================
    // CMD line protocol
    // ================================================
    outEnLowAfterReset: assert property (@(posedge clk) !rst_ |=> !cmdOutEn)
        else $error("cmdOutEn high right after reset");

    startBitLow: assert property (@(posedge clk) disable iff (!rst_)
        $rose(cmdOutEn) |-> !cmdOut)
        else $error("Response does not begin with a 0 start bit");

    burstLength: assert property (@(posedge clk) disable iff (!rst_)
        $fell(cmdOutEn) |-> runLen == 7'(`SD_RESP_BITS))
        else $error("cmdOutEn burst ended after %0d cycles", runLen);

    burstNotLong: assert property (@(posedge clk) disable iff (!rst_)
        cmdOutEn |-> runLen < 7'(`SD_RESP_BITS))
        else $error("cmdOutEn burst longer than a response");

    idleHigh: assert property (@(posedge clk) disable iff (!rst_) !cmdOutEn |-> cmdOut)
        else $error("cmdOut low while the card does not drive");

endmodule

bind sdCardCmdPath sdCardCmdPath_checker protocolCheck (
    .clk      (clk),
    .rst_     (rst_),
    .cmdOut   (cmdOut),
    .cmdOutEn (cmdOutEn)
);

/* verification/sdCardCmdPathTb.sv */
`timescale 1ns/1ps
`include "sd_config.svh"

module sdCardCmdPathTb;

    localparam int unsigned NUM_CMDS   = 21;
    localparam int unsigned MAX_CYCLES = NUM_CMDS * 110 + 200;
    localparam int unsigned LATENCY    = `SD_NCR_CYCLES + 2;

    // What the host expects back for one command
    typedef struct packed {
        logic        valid;
        logic [5:0]  index;
        logic [47:0] frame;
        logic [31:0] endCycle;
    } expEntry;

    // One frame seen on the line
    typedef struct packed {
        logic [47:0] frame;
        logic [31:0] startCycle;
    } capEntry;

    logic clk;
    logic rst_;
    logic cmdIn;
    logic cmdOut;
    logic cmdOutEn;

    int unsigned cycleCnt = 0;
    int unsigned errors   = 0;
    int unsigned checks   = 0;
    expEntry     expQ[$];
    capEntry     capQ[$];

    // Card model
    logic [3:0]  modelState;
    logic [15:0] modelRca;
    logic        modelApp;
    logic        modelCrcErr;
    logic        modelIllegal;

    sdCardCmdPath dut (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdOut   (cmdOut),
        .cmdOutEn (cmdOutEn)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // x^7 + x^3 + 1 over 40 bits sent MSB first
    function automatic logic [6:0] crc7(input logic [39:0] head);
        logic [6:0]  c;
        logic        fb;
        logic [39:0] rest;
        c = 7'd0;
        rest = head;
        repeat (40) begin
            fb = rest[39] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
            rest = rest << 1;
        end
        return c;
    endfunction

    function automatic logic [47:0] replyFrame(input logic [5:0] index, input logic [31:0] arg);
        logic [39:0] head;
        head = {2'b00, index, arg};
        return {head, crc7(head), 1'b1};
    endfunction

    // R1 card status
    function automatic logic [31:0] statusWord(input logic appCmd);
        logic [31:0] s;
        s = 32'd0;
        s[23] = modelCrcErr;
        s[22] = modelIllegal;
        s[12:9] = modelState;
        s[5] = appCmd;
        return s;
    endfunction

    // Expected reply for one command and the card model update
    function automatic logic expectResponse(input logic [5:0] index, input logic [31:0] arg,
                                            input logic badCrc, output logic [47:0] frame);
        logic        app;
        logic        respond;
        logic [15:0] shortStatus;
        frame = 48'd0;
        respond = 1'b0;
        app = modelApp;
        modelApp = 1'b0;
        shortStatus = 16'd0;
        if (badCrc) begin
            modelCrcErr = 1'b1;
        end else if (index == 6'd0) begin
            modelState = 4'd0;
            modelRca = 16'd0;
        end else if (index == 6'd8) begin
            frame = replyFrame(6'd8, {20'd0, arg[11:0]});
            respond = 1'b1;
        end else if (index == 6'd55) begin
            frame = replyFrame(6'd55, statusWord(1'b1));
            modelCrcErr = 1'b0;
            modelIllegal = 1'b0;
            modelApp = 1'b1;
            respond = 1'b1;
        end else if (index == 6'd41 && app) begin
            // R3 carries all ones in place of a CRC
            frame = {2'b00, 6'h3F, `SD_OCR_READY, 7'h7F, 1'b1};
            modelState = 4'd1;
            respond = 1'b1;
        end else if (index == 6'd3) begin
            shortStatus[15] = modelCrcErr;
            shortStatus[14] = modelIllegal;
            shortStatus[12:9] = modelState;
            frame = replyFrame(6'd3, {`SD_ASSIGNED_RCA, shortStatus});
            modelRca = `SD_ASSIGNED_RCA;
            modelState = 4'd3;
            modelCrcErr = 1'b0;
            modelIllegal = 1'b0;
            respond = 1'b1;
        end else if (index == 6'd7) begin
            if (arg[31:16] == modelRca && modelRca != 16'd0) begin
                frame = replyFrame(6'd7, statusWord(1'b0));
                modelState = 4'd4;
                modelCrcErr = 1'b0;
                modelIllegal = 1'b0;
                respond = 1'b1;
            end
        end else begin
            modelIllegal = 1'b1;
        end
        return respond;
    endfunction

    task automatic checkValue(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Host side of the CMD line
    task automatic sendCommand(input logic [5:0] index, input logic [31:0] arg,
                               input logic badCrc);
        logic [39:0] head;
        logic [47:0] bits;
        expEntry     e;
        head = {2'b01, index, arg};
        bits = {head, crc7(head), 1'b1};
        if (badCrc) begin
            bits[1] = ~bits[1];
        end
        e.index = index;
        e.valid = expectResponse(index, arg, badCrc, e.frame);
        repeat (48) begin
            @(posedge clk);
            #2;
            cmdIn = bits[47];
            bits = bits << 1;
        end
        e.endCycle = cycleCnt;
        @(posedge clk);
        #2;
        cmdIn = 1'b1;
        // Gap, reply and two idle cycles
        repeat (LATENCY + `SD_RESP_BITS + 1) @(posedge clk);
        expQ.push_back(e);
    endtask

    initial begin : captureReplies
        capEntry c;
        forever begin
            @(negedge clk);
            if (rst_ && cmdOutEn) begin
                c.startCycle = cycleCnt;
                c.frame = {47'd0, cmdOut};
                repeat (47) begin
                    @(negedge clk);
                    c.frame = {c.frame[46:0], cmdOut};
                end
                capQ.push_back(c);
            end
        end
    end

    initial begin : compareReplies
        expEntry e;
        capEntry c;
        forever begin
            @(negedge clk);
            if (expQ.size() > 0) begin
                e = expQ.pop_front();
                if (e.valid && capQ.size() == 0) begin
                    errors++;
                    $display("No response to CMD%0d at %0t", e.index, $time);
                end else if (!e.valid && capQ.size() > 0) begin
                    errors++;
                    c = capQ.pop_front();
                    $display("Response %h to CMD%0d, none was due", c.frame, e.index);
                end else if (e.valid) begin
                    c = capQ.pop_front();
                    checkValue(64'(c.frame), 64'(e.frame), $sformatf("CMD%0d reply", e.index));
                    checkValue(64'(c.startCycle - e.endCycle), 64'(LATENCY),
                               $sformatf("CMD%0d latency", e.index));
                end
            end
        end
    end

    initial begin : testSequence
        void'($urandom(32'h31a0_406b));
        cmdIn = 1'b1;
        rst_ = 1'b0;
        modelState = 4'd0;
        modelRca = 16'd0;
        modelApp = 1'b0;
        modelCrcErr = 1'b0;
        modelIllegal = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_ = 1'b1;

        repeat (4) sendCommand(6'd8, $urandom, 1'b0);

        // Bring-up to transfer state
        sendCommand(6'd0, 32'd0, 1'b0);
        sendCommand(6'd55, 32'd0, 1'b0);
        sendCommand(6'd41, 32'h40FF8000, 1'b0);
        sendCommand(6'd3, 32'd0, 1'b0);
        sendCommand(6'd7, {`SD_ASSIGNED_RCA, 16'd0}, 1'b0);
        sendCommand(6'd55, {`SD_ASSIGNED_RCA, 16'd0}, 1'b0);

        // CRC error is reported once
        sendCommand(6'd8, 32'h0000_01AA, 1'b1);
        sendCommand(6'd55, {`SD_ASSIGNED_RCA, 16'd0}, 1'b0);
        sendCommand(6'd55, {`SD_ASSIGNED_RCA, 16'd0}, 1'b0);

        // Unknown index and then ACMD41 with no prefix
        sendCommand(6'd13, 32'd0, 1'b0);
        sendCommand(6'd55, {`SD_ASSIGNED_RCA, 16'd0}, 1'b0);
        sendCommand(6'd8, 32'h0000_0155, 1'b0);
        sendCommand(6'd41, 32'h40FF8000, 1'b0);
        sendCommand(6'd55, {`SD_ASSIGNED_RCA, 16'd0}, 1'b0);

        // Wrong address on CMD7
        sendCommand(6'd8, 32'h0000_0AA5, 1'b0);
        sendCommand(6'd7, 32'h1234_0000, 1'b0);
        sendCommand(6'd55, {`SD_ASSIGNED_RCA, 16'd0}, 1'b0);

        repeat (2) @(posedge clk);
        if (capQ.size() > 0) begin
            errors++;
            $display("%0d response frames left with no command to match", capQ.size());
        end
        $display("Closing count: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/sdCmdPkg.sv
hw/sdRespPkg.sv
hw/sdCrc7.sv
hw/sdCmdReceiver.sv
hw/sdCmdDecoder.sv
hw/sdRespTransmitter.sv
hw/sdCardCmdPath.sv
verification/sdCardCmdPath_checker.sv
verification/sdCardCmdPathTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module sdCardCmdPathTb -f files.f -o simv

output=$(./obj_dir/simv || true)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1
